//--- rv_id_stage.f
source/rv_id_pkg.sv
source/rv_decoder.sv
source/rv_operand_read.sv
source/rv_id_ex_reg.sv
source/rv_id_stage.sv
verification/rv_id_clk_gen.sv
verification/rv_id_asserts.sv
verification/rv_id_tb.sv

//--- verification/rv_id_tb.sv
`timescale 1ns/1ns

module rv_id_tb;

  localparam int N_DEC    = 10;
  localparam int WAIT_MAX = 50;

  typedef struct {
    string               name;
    rv_id_pkg::word_t    instr;
    rv_id_pkg::id_ctrl_t ctrl;
    rv_id_pkg::reg_idx_t rd;
    rv_id_pkg::reg_idx_t rs1;
    rv_id_pkg::reg_idx_t rs2;
    logic [2:0]          funct3;
    rv_id_pkg::word_t    imm;
    logic                rs1_used;
    logic                rs2_used;
  } decode_entry_t;

  logic                clk;
  logic                rst_n_i;
  logic                s_valid;
  logic                data_hazard;
  logic                flush;
  logic                m_ready;
  rv_id_pkg::word_t    instr;
  rv_id_pkg::word_t    pc;
  rv_id_pkg::word_t    pc_plus4;
  rv_id_pkg::wb_t      wb;
  logic                s_ready;
  logic                m_valid;
  rv_id_pkg::id_ex_t   id_ex;
  rv_id_pkg::reg_idx_t rs1_idx;
  rv_id_pkg::reg_idx_t rs2_idx;
  logic                rs1_used;
  logic                rs2_used;

  decode_entry_t    dec_tbl [N_DEC];
  rv_id_pkg::word_t model_regs [32];
  rv_id_pkg::word_t sent_q [$];
  rv_id_pkg::word_t seen_q [$];
  logic [31:0]      lcg_state = 32'h4433_c60d;
  int               test_err;
  int               pass_cnt;
  int               fail_cnt;

  rv_id_clk_gen u_clk_gen (
    .clk     (clk),
    .rst_n_i (rst_n_i)
  );

  rv_id_stage DUT (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .s_valid_i     (s_valid),
    .data_hazard_i (data_hazard),
    .flush_i       (flush),
    .m_ready_i     (m_ready),
    .instr_i       (instr),
    .pc_i          (pc),
    .pc_plus4_i    (pc_plus4),
    .wb_i          (wb),
    .s_ready_o     (s_ready),
    .m_valid_o     (m_valid),
    .id_ex_o       (id_ex),
    .rs1_o         (rs1_idx),
    .rs2_o         (rs2_idx),
    .rs1_used_o    (rs1_used),
    .rs2_used_o    (rs2_used)
  );

  // Transfers to EX are sampled mid-cycle before the edge that takes them
  always @(negedge clk) begin
    if (rst_n_i && m_valid && m_ready) begin
      seen_q.push_back(id_ex.instr);
    end
  end

  // ====================
  // Helpers
  // ====================

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Arguments in id_ctrl_t field order
  function automatic rv_id_pkg::id_ctrl_t pack_ctrl(
    input logic rw, input logic mr, input logic mw, input logic [1:0] a, input logic b,
    input logic [1:0] op, input logic [1:0] res, input logic br, input logic jal,
    input logic jalr, input logic [1:0] trap);
    return {rw, mr, mw, a, b, op, res, br, jal, jalr, trap};
  endfunction

  task automatic check_val(input string field, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error @%0t: %s is %h, expected %h", $time, field, got, exp);
      test_err++;
    end
  endtask

  task automatic end_test(input string name);
    if (test_err == 0) begin
      pass_cnt++;
      $display("passed: %s", name);
    end else begin
      fail_cnt++;
      $display("failed: %s (%0d errors)", name, test_err);
    end
    test_err = 0;
  endtask

  task automatic drive_instr(input rv_id_pkg::word_t w, input rv_id_pkg::word_t addr);
    @(posedge clk);
    s_valid  <= 1'b1;
    instr    <= w;
    pc       <= addr;
    pc_plus4 <= addr + 32'd4;
    sent_q.push_back(w);
  endtask

  task automatic wait_accept();
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!s_ready && cnt < WAIT_MAX) begin
      @(negedge clk);
      cnt++;
    end
    if (!s_ready) begin
      $display("Timeout: instruction not accepted within %0d cycles", WAIT_MAX);
      test_err++;
    end
    @(posedge clk);
    s_valid <= 1'b0;
    wb      <= '0;
  endtask

  task automatic wait_valid();
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!m_valid && cnt < WAIT_MAX) begin
      @(negedge clk);
      cnt++;
    end
    if (!m_valid) begin
      $display("Timeout: m_valid_o did not rise within %0d cycles", WAIT_MAX);
      test_err++;
    end
  endtask

  // Every register gets an LCG value including x0
  task automatic preload_regs();
    rv_id_pkg::word_t val;
    for (int r = 0; r < 32; r++) begin
      val = lcg_next();
      @(posedge clk);
      wb <= '{en: 1'b1, rd: rv_id_pkg::reg_idx_t'(r), data: val};
      model_regs[r] = (r == 0) ? '0 : val;
    end
    @(posedge clk);
    wb <= '0;
  endtask

  // name, instr, ctrl, rd, rs1, rs2, funct3, imm, rs1 used, rs2 used
  task automatic fill_table();
    dec_tbl[0] = '{"sub", 32'h407302B3, pack_ctrl(1,0,0,0,0,2,0,0,0,0,0), 5, 6, 7, 0,
                   32'h0, 1, 1};
    dec_tbl[1] = '{"addi", 32'hFFB10093, pack_ctrl(1,0,0,0,1,2,0,0,0,0,0), 1, 2, 27, 0,
                   32'hFFFF_FFFB, 1, 0};
    dec_tbl[2] = '{"lw", 32'h00812203, pack_ctrl(1,1,0,0,1,0,1,0,0,0,0), 4, 2, 8, 2,
                   32'h8, 1, 0};
    dec_tbl[3] = '{"sw", 32'h0071A623, pack_ctrl(0,0,1,0,1,0,0,0,0,0,0), 12, 3, 7, 2,
                   32'hC, 1, 1};
    dec_tbl[4] = '{"beq", 32'hFE208CE3, pack_ctrl(0,0,0,0,0,1,0,1,0,0,0), 25, 1, 2, 0,
                   32'hFFFF_FFF8, 1, 1};
    dec_tbl[5] = '{"jal", 32'h001000EF, pack_ctrl(1,0,0,1,1,0,2,0,1,0,0), 1, 0, 1, 0,
                   32'h800, 0, 0};
    dec_tbl[6] = '{"jalr", 32'h004302E7, pack_ctrl(1,0,0,0,1,0,2,0,0,1,0), 5, 6, 4, 0,
                   32'h4, 1, 0};
    dec_tbl[7] = '{"lui", 32'h80001537, pack_ctrl(1,0,0,2,1,0,0,0,0,0,0), 10, 0, 0, 1,
                   32'h8000_1000, 0, 0};
    dec_tbl[8] = '{"auipc", 32'h00010117, pack_ctrl(1,0,0,1,1,0,0,0,0,0,0), 2, 2, 0, 0,
                   32'h0001_0000, 0, 0};
    // SYSTEM opcode is outside the decoded set
    dec_tbl[9] = '{"ecall", 32'h00000073, pack_ctrl(0,0,0,0,0,0,0,0,0,0,1), 0, 0, 0, 0,
                   32'h0, 0, 0};
  endtask

  task automatic check_decode(input decode_entry_t e, input rv_id_pkg::word_t addr);
    check_val("ctrl", id_ex.ctrl, e.ctrl);
    check_val("rd", id_ex.rd, e.rd);
    check_val("rs1", id_ex.rs1, e.rs1);
    check_val("rs2", id_ex.rs2, e.rs2);
    check_val("funct3", id_ex.funct3, e.funct3);
    check_val("imm", id_ex.imm, e.imm);
    check_val("instr", id_ex.instr, e.instr);
    check_val("pc", id_ex.pc, addr);
    check_val("pc_plus4", id_ex.pc_plus4, addr + 32'd4);
    check_val("rs1_data", id_ex.rs1_data, model_regs[e.rs1]);
    check_val("rs2_data", id_ex.rs2_data, model_regs[e.rs2]);
    // IF still holds the instruction, so the hazard-unit outputs decode it
    check_val("rs1_o", rs1_idx, e.rs1);
    check_val("rs2_o", rs2_idx, e.rs2);
    check_val("rs1_used_o", rs1_used, e.rs1_used);
    check_val("rs2_used_o", rs2_used, e.rs2_used);
  endtask

  // ====================
  // Test sequence
  // ====================

  initial begin
    int               cnt;
    int               stall;
    rv_id_pkg::id_ex_t snap;
    rv_id_pkg::word_t  bypass_val;

    s_valid     = 1'b0;
    data_hazard = 1'b0;
    flush       = 1'b0;
    m_ready     = 1'b1;
    instr       = rv_id_pkg::I_NOP;
    pc          = '0;
    pc_plus4    = 32'd4;
    wb          = '0;
    test_err    = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    fill_table();

    cnt = 0;
    while (rst_n_i !== 1'b1 && cnt < WAIT_MAX) begin
      @(posedge clk);
      cnt++;
    end
    if (rst_n_i !== 1'b1) begin
      $display("Timeout: reset was never released");
      test_err++;
    end
    @(negedge clk);
    check_val("m_valid after reset", m_valid, 1'b0);
    check_val("ctrl after reset", id_ex.ctrl, '0);
    end_test("reset");

    preload_regs();
    for (int i = 0; i < N_DEC; i++) begin
      drive_instr(dec_tbl[i].instr, 32'h1000 + 4 * i);
      wait_accept();
      wait_valid();
      check_decode(dec_tbl[i], 32'h1000 + 4 * i);
      end_test({"decode ", dec_tbl[i].name});
    end

    // addi x9, x8, 1 while x8 is written in the same cycle
    bypass_val = lcg_next();
    drive_instr(32'h00140493, 32'h2000);
    wb <= '{en: 1'b1, rd: 5'd8, data: bypass_val};
    model_regs[8] = bypass_val;
    wait_accept();
    wait_valid();
    check_val("rs1_data", id_ex.rs1_data, bypass_val);
    end_test("write-through bypass");

    drive_instr(32'h002081B3, 32'h3000);
    wait_accept();
    m_ready <= 1'b0;
    wait_valid();
    snap = id_ex;
    check_val("instr", id_ex.instr, 32'h002081B3);
    drive_instr(32'h0062E233, 32'h3004);
    stall = 2 + int'(lcg_next() % 32'd4);
    for (cnt = 0; cnt < stall; cnt++) begin
      @(negedge clk);
      check_val("m_valid stalled", m_valid, 1'b1);
      check_val("s_ready stalled", s_ready, 1'b0);
      if (id_ex !== snap) begin
        $display("** Error @%0t: id_ex_o changed under back-pressure", $time);
        test_err++;
      end
    end
    @(posedge clk);
    m_ready <= 1'b1;
    wait_accept();
    wait_valid();
    check_val("instr", id_ex.instr, 32'h0062E233);
    end_test("back-pressure");

    drive_instr(32'h00C58533, 32'h4000);
    data_hazard <= 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_val("s_ready in hazard", s_ready, 1'b0);
      check_val("m_valid in hazard", m_valid, 1'b0);
      check_val("ctrl in hazard", id_ex.ctrl, '0);
    end
    @(posedge clk);
    data_hazard <= 1'b0;
    wait_accept();
    wait_valid();
    check_val("instr", id_ex.instr, 32'h00C58533);
    @(negedge clk);
    check_val("m_valid after delivery", m_valid, 1'b0);
    end_test("hazard bubble");

    drive_instr(32'h00F00713, 32'h5000);
    wait_accept();
    m_ready <= 1'b0;
    flush   <= 1'b1;
    // Flushed instruction never reaches EX
    void'(sent_q.pop_back());
    @(posedge clk);
    flush   <= 1'b0;
    m_ready <= 1'b1;
    @(negedge clk);
    check_val("m_valid after flush", m_valid, 1'b0);
    check_val("ctrl after flush", id_ex.ctrl, '0);
    check_val("instr after flush", id_ex.instr, rv_id_pkg::I_NOP);
    end_test("flush");

    @(negedge clk);
    if (seen_q.size() != sent_q.size()) begin
      $display("** Error @%0t: %0d transfers seen, %0d expected", $time,
               seen_q.size(), sent_q.size());
      test_err++;
    end else begin
      foreach (sent_q[k]) begin
        check_val("transfer order", seen_q[k], sent_q[k]);
      end
    end
    end_test("transfer order");

    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- verification/rv_id_asserts.sv
`timescale 1ns/1ns

module rv_id_asserts (
  input logic              clk,
  input logic              rst_n_i,
  input logic              m_valid_i,
  input logic              m_ready_i,
  input logic              flush_i,
  input rv_id_pkg::id_ex_t id_ex_i
);

  // ====================
  // Output handshake
  // ====================

  // Stalled output keeps valid
  assert property (@(posedge clk) disable iff (!rst_n_i)
    (m_valid_i && !m_ready_i && !flush_i) |=> m_valid_i)
    else $error("m_valid_o dropped while stalled by m_ready_i");

  // Stalled output keeps its value
  assert property (@(posedge clk) disable iff (!rst_n_i)
    (m_valid_i && !m_ready_i && !flush_i) |=> $stable(id_ex_i))
    else $error("id_ex_o changed while stalled by m_ready_i");

  // Flush empties the register
  assert property (@(posedge clk) disable iff (!rst_n_i)
    flush_i |=> !m_valid_i)
    else $error("m_valid_o high in the cycle after flush_i");

endmodule

bind rv_id_ex_reg rv_id_asserts u_asserts (
  .clk       (clk),
  .rst_n_i   (rst_n_i),
  .m_valid_i (m_valid_o),
  .m_ready_i (m_ready_i),
  .flush_i   (flush_i),
  .id_ex_i   (id_ex_o)
);

//--- verification/rv_id_clk_gen.sv
`timescale 1ns/1ns

module rv_id_clk_gen (
  output logic clk,
  output logic rst_n_i
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset low for the first 16 rising edges
  initial begin
    rst_n_i = 1'b0;
    repeat (16) @(posedge clk);
    rst_n_i <= 1'b1;
  end

endmodule

//--- source/rv_id_stage.sv
`timescale 1ns/1ns

module rv_id_stage (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                s_valid_i,
  input  logic                data_hazard_i,
  input  logic                flush_i,
  input  logic                m_ready_i,
  input  rv_id_pkg::word_t    instr_i,
  input  rv_id_pkg::word_t    pc_i,
  input  rv_id_pkg::word_t    pc_plus4_i,
  input  rv_id_pkg::wb_t      wb_i,
  output logic                s_ready_o,
  output logic                m_valid_o,
  output rv_id_pkg::id_ex_t   id_ex_o,
  output rv_id_pkg::reg_idx_t rs1_o,
  output rv_id_pkg::reg_idx_t rs2_o,
  output logic                rs1_used_o,
  output logic                rs2_used_o
);

  rv_id_pkg::dec_t      dec;
  rv_id_pkg::operands_t operands;

  rv_decoder u_decoder (
    .instr_i    (instr_i),
    .dec_o      (dec),
    .rs1_used_o (rs1_used_o),
    .rs2_used_o (rs2_used_o)
  );

  // Indices also go out to the hazard unit
  assign rs1_o = dec.rs1;
  assign rs2_o = dec.rs2;

  rv_operand_read u_operand_read (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rs1_i      (dec.rs1),
    .rs2_i      (dec.rs2),
    .wb_i       (wb_i),
    .operands_o (operands)
  );

  rv_id_ex_reg u_id_ex_reg (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .s_valid_i     (s_valid_i),
    .dec_i         (dec),
    .operands_i    (operands),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .pc_plus4_i    (pc_plus4_i),
    .data_hazard_i (data_hazard_i),
    .flush_i       (flush_i),
    .m_ready_i     (m_ready_i),
    .s_ready_o     (s_ready_o),
    .m_valid_o     (m_valid_o),
    .id_ex_o       (id_ex_o)
  );

endmodule

//--- source/rv_id_ex_reg.sv
`timescale 1ns/1ns

module rv_id_ex_reg (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 s_valid_i,
  input  rv_id_pkg::dec_t      dec_i,
  input  rv_id_pkg::operands_t operands_i,
  input  rv_id_pkg::word_t     instr_i,
  input  rv_id_pkg::word_t     pc_i,
  input  rv_id_pkg::word_t     pc_plus4_i,
  input  logic                 data_hazard_i,
  input  logic                 flush_i,
  input  logic                 m_ready_i,
  output logic                 s_ready_o,
  output logic                 m_valid_o,
  output rv_id_pkg::id_ex_t    id_ex_o
);

  logic              m_valid_q;
  logic              advance;
  logic              accept;
  rv_id_pkg::id_ex_t in_val;
  rv_id_pkg::id_ex_t id_ex_q;

  // Register can take new contents when EX drains it or it is empty
  assign advance   = m_ready_i || !m_valid_q;
  assign s_ready_o = m_ready_i && !data_hazard_i;
  assign accept    = s_valid_i && s_ready_o;

  always_comb begin
    in_val.ctrl     = dec_i.ctrl;
    in_val.rd       = dec_i.rd;
    in_val.rs1      = dec_i.rs1;
    in_val.rs2      = dec_i.rs2;
    in_val.funct3   = dec_i.funct3;
    in_val.funct7   = dec_i.funct7;
    in_val.instr    = instr_i;
    in_val.imm      = dec_i.imm;
    in_val.pc       = pc_i;
    in_val.pc_plus4 = pc_plus4_i;
    in_val.rs1_data = operands_i.rs1_data;
    in_val.rs2_data = operands_i.rs2_data;
  end

  // ====================
  // Pipeline register
  // ====================

  // Flush wins over advance and bubble
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      m_valid_q    <= 1'b0;
      id_ex_q.ctrl <= '0;
    end else if (flush_i) begin
      m_valid_q     <= 1'b0;
      id_ex_q.ctrl  <= '0;
      id_ex_q.instr <= rv_id_pkg::I_NOP;
    end else if (advance) begin
      m_valid_q <= accept;
      if (accept) begin
        id_ex_q <= in_val;
      end else begin
        // Bubble on a hazard or when nothing is offered
        id_ex_q.ctrl <= '0;
      end
    end
  end

  assign m_valid_o = m_valid_q;
  assign id_ex_o   = id_ex_q;

endmodule

//--- source/rv_operand_read.sv
`timescale 1ns/1ns

module rv_operand_read (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  rv_id_pkg::reg_idx_t  rs1_i,
  input  rv_id_pkg::reg_idx_t  rs2_i,
  input  rv_id_pkg::wb_t       wb_i,
  output rv_id_pkg::operands_t operands_o
);

  // x0 has no storage
  rv_id_pkg::word_t regs [31:1];

  logic wr_en;

  assign wr_en = wb_i.en && (wb_i.rd != '0);

  // ====================
  // Write port
  // ====================

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // ====================
  // Read ports
  // ====================

  // Same-cycle write returns the new value
  function automatic rv_id_pkg::word_t read_port(input rv_id_pkg::reg_idx_t idx);
    rv_id_pkg::word_t val;
    if (idx == '0) begin
      val = '0;
    end else if (wr_en && (wb_i.rd == idx)) begin
      val = wb_i.data;
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  always_comb begin
    operands_o.rs1_data = read_port(rs1_i);
    operands_o.rs2_data = read_port(rs2_i);
  end

endmodule

//--- source/rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder (
  input  rv_id_pkg::word_t instr_i,
  output rv_id_pkg::dec_t  dec_o,
  output logic             rs1_used_o,
  output logic             rs2_used_o
);

  rv_id_pkg::opcode_e opcode;
  rv_id_pkg::word_t   imm_i;
  rv_id_pkg::word_t   imm_s;
  rv_id_pkg::word_t   imm_b;
  rv_id_pkg::word_t   imm_u;
  rv_id_pkg::word_t   imm_j;

  assign opcode = rv_id_pkg::opcode_e'(instr_i[6:0]);

  // ====================
  // Immediate formats
  // ====================

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // ====================
  // Control decode
  // ====================

  always_comb begin
    dec_o        = '0;
    dec_o.rd     = instr_i[11:7];
    dec_o.rs1    = instr_i[19:15];
    dec_o.rs2    = instr_i[24:20];
    dec_o.funct3 = instr_i[14:12];
    dec_o.funct7 = instr_i[31:25];
    rs1_used_o   = 1'b1;
    rs2_used_o   = 1'b0;

    case (opcode)
      rv_id_pkg::OP_OP: begin
        dec_o.ctrl.reg_write = 1'b1;
        dec_o.ctrl.alu_op    = rv_id_pkg::ALU_FUNCT;
        rs2_used_o           = 1'b1;
      end
      rv_id_pkg::OP_IMM: begin
        dec_o.ctrl.reg_write = 1'b1;
        dec_o.ctrl.alu_b_src = 1'b1;
        dec_o.ctrl.alu_op    = rv_id_pkg::ALU_FUNCT;
        dec_o.imm            = imm_i;
      end
      rv_id_pkg::OP_LOAD: begin
        dec_o.ctrl.reg_write = 1'b1;
        dec_o.ctrl.mem_read  = 1'b1;
        dec_o.ctrl.alu_b_src = 1'b1;
        dec_o.ctrl.res_src   = rv_id_pkg::RES_MEM;
        dec_o.imm            = imm_i;
      end
      rv_id_pkg::OP_STORE: begin
        dec_o.ctrl.mem_write = 1'b1;
        dec_o.ctrl.alu_b_src = 1'b1;
        dec_o.imm            = imm_s;
        rs2_used_o           = 1'b1;
      end
      rv_id_pkg::OP_BRANCH: begin
        // Compare rs1 against rs2 and take the target from pc + imm in EX
        dec_o.ctrl.alu_op    = rv_id_pkg::ALU_SUB_CMP;
        dec_o.ctrl.is_branch = 1'b1;
        dec_o.imm            = imm_b;
        rs2_used_o           = 1'b1;
      end
      rv_id_pkg::OP_JAL: begin
        dec_o.ctrl.reg_write = 1'b1;
        dec_o.ctrl.alu_a_src = rv_id_pkg::A_PC;
        dec_o.ctrl.alu_b_src = 1'b1;
        dec_o.ctrl.res_src   = rv_id_pkg::RES_PC4;
        dec_o.ctrl.is_jal    = 1'b1;
        dec_o.imm            = imm_j;
        rs1_used_o           = 1'b0;
      end
      rv_id_pkg::OP_JALR: begin
        dec_o.ctrl.reg_write = 1'b1;
        dec_o.ctrl.alu_b_src = 1'b1;
        dec_o.ctrl.res_src   = rv_id_pkg::RES_PC4;
        dec_o.ctrl.is_jalr   = 1'b1;
        dec_o.imm            = imm_i;
      end
      rv_id_pkg::OP_LUI: begin
        dec_o.ctrl.reg_write = 1'b1;
        dec_o.ctrl.alu_a_src = rv_id_pkg::A_ZERO;
        dec_o.ctrl.alu_b_src = 1'b1;
        dec_o.imm            = imm_u;
        rs1_used_o           = 1'b0;
      end
      rv_id_pkg::OP_AUIPC: begin
        dec_o.ctrl.reg_write = 1'b1;
        dec_o.ctrl.alu_a_src = rv_id_pkg::A_PC;
        dec_o.ctrl.alu_b_src = 1'b1;
        dec_o.imm            = imm_u;
        rs1_used_o           = 1'b0;
      end
      default: begin
        // No writes and no memory access for an illegal opcode
        dec_o.ctrl.trap = rv_id_pkg::TRAP_INVALID;
        rs1_used_o      = 1'b0;
      end
    endcase
  end

endmodule

//--- source/rv_id_pkg.sv
package rv_id_pkg;

  // ====================
  // Widths and constants
  // ====================

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [REG_AW-1:0] reg_idx_t;

  // addi x0, x0, 0
  localparam word_t I_NOP = 32'h0000_0013;

  // ====================
  // Field encodings
  // ====================

  typedef enum logic [6:0] {
    OP_OP     = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111
  } opcode_e;

  // ALU operand A source
  typedef enum logic [1:0] {
    A_RS1  = 2'd0,
    A_PC   = 2'd1,
    A_ZERO = 2'd2
  } alu_a_src_e;

  // Result written back to rd
  typedef enum logic [1:0] {
    RES_ALU = 2'd0,
    RES_MEM = 2'd1,
    RES_PC4 = 2'd2
  } res_src_e;

  // ALU operation class that EX refines with funct3/funct7
  typedef enum logic [1:0] {
    ALU_ADD     = 2'd0,
    ALU_SUB_CMP = 2'd1,
    ALU_FUNCT   = 2'd2
  } alu_op_e;

  typedef enum logic [1:0] {
    TRAP_NONE    = 2'd0,
    TRAP_INVALID = 2'd1
  } trap_e;

  // ====================
  // Bundles
  // ====================

  typedef struct packed {
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    alu_a_src_e alu_a_src;
    logic       alu_b_src;  // 1 selects the immediate
    alu_op_e    alu_op;
    res_src_e   res_src;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    trap_e      trap;
  } id_ctrl_t;

  typedef struct packed {
    id_ctrl_t   ctrl;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm;
  } dec_t;

  typedef struct packed {
    logic     en;
    reg_idx_t rd;
    word_t    data;
  } wb_t;

  typedef struct packed {
    word_t rs1_data;
    word_t rs2_data;
  } operands_t;

  typedef struct packed {
    id_ctrl_t   ctrl;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      instr;
    word_t      imm;
    word_t      pc;
    word_t      pc_plus4;
    word_t      rs1_data;
    word_t      rs2_data;
  } id_ex_t;

endpackage
